// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP      = tb_ex_pipeline
FILELIST = files.f
OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = TESTBENCH FAILED
PASSMSG  = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: alu.sv
// RV32I integer ALU
`timescale 1ns/1ps

module alu
    import rv_ex_pkg::*;
(
    input  alu_fn_t fn,
    input  word_t   a,
    input  word_t   b,
    output word_t   y,
    output logic    zero,
    output logic    lt,
    output logic    ltu
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // Shift amount from low five bits

    // Compare flags independent of fn
    assign zero = (a == b);
    assign lt   = ($signed(a) < $signed(b));
    assign ltu  = (a < b);

    always_comb
    begin
        case (fn)
            alu_add:
                y = a + b;
            alu_sub:
                y = a - b;
            alu_sll:
                y = a << shamt;
            alu_slt:
                y = word_t'(lt);
            alu_sltu:
                y = word_t'(ltu);
            alu_xor:
                y = a ^ b;
            alu_srl:
                y = a >> shamt;
            alu_sra:
                y = word_t'($signed(a) >>> shamt);   // Sign fill
            alu_or:
                y = a | b;
            alu_and:
                y = a & b;
            default:
                y = '0;
        endcase
    end

endmodule

// File: branch_compare.sv
// Branch resolution and target
`timescale 1ns/1ps

module branch_compare
    import rv_ex_pkg::*;
(
    input  branch_t branch_type,
    input  logic    branch,
    input  logic    jump,
    input  logic    jalr,
    input  logic    zero,
    input  logic    lt,
    input  logic    ltu,
    input  word_t   pc,
    input  word_t   rs1,
    input  word_t   imm,
    output logic    redirect,
    output word_t   target
);

    logic  taken;
    word_t jalr_sum;

    // Flags come from the ALU compare of rs1 against rs2
    always_comb
    begin
        case (branch_type)
            br_beq:  taken = zero;
            br_bne:  taken = ~zero;
            br_blt:  taken = lt;
            br_bge:  taken = ~lt;
            br_bltu: taken = ltu;
            br_bgeu: taken = ~ltu;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = jump | (branch & taken);

    assign jalr_sum = rs1 + imm;

    // JALR drops bit 0 of its sum
    assign target = jalr ? (jalr_sum & ~word_t'(1)) : (pc + imm);

endmodule

// File: ex_pipeline.sv
// RV32I execute cluster top
`timescale 1ns/1ps

module ex_pipeline
    import rv_ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  id_ex_t  issue,
    input  wb_fwd_t wb,
    output ex_mem_t ex_mem
);

    word_t rs1_fwd;
    word_t rs2_fwd;

    // Bypass sees the registered EX/MEM bundle and the write-back port
    operand_forward u_forward (
        .rs1_addr  (issue.rs1_addr),
        .rs2_addr  (issue.rs2_addr),
        .rs1_value (issue.rs1_value),
        .rs2_value (issue.rs2_value),
        .ex_mem    (ex_mem),
        .wb        (wb),
        .rs1_fwd   (rs1_fwd),
        .rs2_fwd   (rs2_fwd)
    );

    execute_stage u_execute (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .issue   (issue),
        .rs1_fwd (rs1_fwd),
        .rs2_fwd (rs2_fwd),
        .ex_mem  (ex_mem)
    );

endmodule

// File: ex_pipeline_assert.sv
// Execute cluster output checks
`timescale 1ns/1ps

module ex_pipeline_assert
    import rv_ex_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    stall,
    input ex_mem_t ex_mem
);

    // First edge out of reset sees the cleared bundle
    property reset_clears;
        @(posedge clk) $fell(rst) |-> (!ex_mem.valid && !ex_mem.pc_redirect);
    endproperty

    property stall_holds;
        @(posedge clk) disable iff (rst) stall |=> $stable(ex_mem);
    endproperty

    property bubble_quiet;
        @(posedge clk) disable iff (rst)
            !ex_mem.valid |-> !(ex_mem.reg_write || ex_mem.mem_write || ex_mem.pc_redirect);
    endproperty

    assert property (reset_clears) else $error("ex_mem control bits set out of reset");
    assert property (stall_holds) else $error("ex_mem changed during a stall");
    assert property (bubble_quiet) else $error("bubble raised a side effect bit");

endmodule

bind ex_pipeline ex_pipeline_assert u_assert (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .ex_mem (ex_mem)
);

// File: execute_stage.sv
// ID/EX and EX/MEM execute stage
`timescale 1ns/1ps
`include "rv_ex_cfg.svh"

module execute_stage
    import rv_ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  id_ex_t  issue,
    input  word_t   rs1_fwd,
    input  word_t   rs2_fwd,
    output ex_mem_t ex_mem
);

    id_ex_t  id_ex_q;
    alu_fn_t fn;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_y;
    word_t   target;
    logic    zero;
    logic    lt;
    logic    ltu;
    logic    redirect;
    logic    is_jalr;
    logic    is_link;

    // Issue latch with sources replaced by bypassed values
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            id_ex_q <= '0;
        else if (!stall)
        begin
            id_ex_q           <= issue;
            id_ex_q.rs1_value <= rs1_fwd;
            id_ex_q.rs2_value <= rs2_fwd;
        end
    end

    assign is_jalr = (id_ex_q.op_class == oc_jalr);
    assign is_link = is_jalr || (id_ex_q.op_class == oc_jal);

    // Link result is always pc + step
    assign fn = is_link ? alu_add : id_ex_q.alu_fn;

    // Operand select by class
    always_comb
    begin
        case (id_ex_q.op_class)
            oc_load_store:
            begin
                op_a = id_ex_q.rs1_value;
                op_b = id_ex_q.imm;
            end
            oc_branch:
            begin
                op_a = id_ex_q.rs1_value;
                op_b = id_ex_q.rs2_value;
            end
            oc_reg_imm:
            begin
                op_a = id_ex_q.rs1_value;
                op_b = id_ex_q.alu_src ? id_ex_q.imm : id_ex_q.rs2_value;
            end
            oc_jal, oc_jalr:
            begin
                op_a = id_ex_q.pc;
                op_b = word_t'(`PC_STEP);
            end
            oc_lui:
            begin
                op_a = id_ex_q.imm;
                op_b = '0;
            end
            oc_auipc:
            begin
                op_a = id_ex_q.pc;
                op_b = id_ex_q.imm;
            end
            default:
            begin
                op_a = '0;
                op_b = '0;
            end
        endcase
    end

    alu u_alu (
        .fn   (fn),
        .a    (op_a),
        .b    (op_b),
        .y    (alu_y),
        .zero (zero),
        .lt   (lt),
        .ltu  (ltu)
    );

    branch_compare u_branch (
        .branch_type (id_ex_q.branch_type),
        .branch      (id_ex_q.branch),
        .jump        (id_ex_q.jump),
        .jalr        (is_jalr),
        .zero        (zero),
        .lt          (lt),
        .ltu         (ltu),
        .pc          (id_ex_q.pc),
        .rs1         (id_ex_q.rs1_value),
        .imm         (id_ex_q.imm),
        .redirect    (redirect),
        .target      (target)
    );

    // Result latch keeps every side effect of a bubble low
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ex_mem <= '0;
        else if (!stall)
        begin
            ex_mem.valid           <= id_ex_q.valid;
            ex_mem.result          <= alu_y;
            ex_mem.store_data      <= id_ex_q.rs2_value;
            ex_mem.rd              <= id_ex_q.rd;
            ex_mem.reg_write       <= id_ex_q.valid & id_ex_q.reg_write;
            ex_mem.mem_read        <= id_ex_q.valid & id_ex_q.mem_read;
            ex_mem.mem_write       <= id_ex_q.valid & id_ex_q.mem_write;
            ex_mem.mem_to_reg      <= id_ex_q.mem_to_reg;
            ex_mem.pc_redirect     <= id_ex_q.valid & redirect;
            ex_mem.redirect_target <= target;
        end
    end

endmodule

// File: files.f
+incdir+.
rv_ex_pkg.sv
alu.sv
branch_compare.sv
operand_forward.sv
execute_stage.sv
ex_pipeline.sv
ex_pipeline_assert.sv
tb_ex_pipeline.sv

// File: operand_forward.sv
// Source operand bypass
`timescale 1ns/1ps

module operand_forward
    import rv_ex_pkg::*;
(
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  word_t     rs1_value,
    input  word_t     rs2_value,
    input  ex_mem_t   ex_mem,
    input  wb_fwd_t   wb,
    output word_t     rs1_fwd,
    output word_t     rs2_fwd
);

    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;

    // EX/MEM checked first so it wins over write-back
    function automatic fwd_sel_t pick_source(reg_addr_t src, ex_mem_t em, wb_fwd_t w);
        if (em.valid && em.reg_write && (em.rd != '0) && (em.rd == src))
            return fwd_from_ex_mem;
        else if (w.reg_write && (w.rd != '0) && (w.rd == src))
            return fwd_from_wb;
        else
            return fwd_none;
    endfunction

    function automatic word_t mux_source(fwd_sel_t sel, word_t reg_value, word_t em_value,
                                         word_t wb_value);
        case (sel)
            fwd_from_ex_mem: return em_value;
            fwd_from_wb:     return wb_value;
            default:         return reg_value;
        endcase
    endfunction

    assign rs1_sel = pick_source(rs1_addr, ex_mem, wb);
    assign rs2_sel = pick_source(rs2_addr, ex_mem, wb);

    assign rs1_fwd = mux_source(rs1_sel, rs1_value, ex_mem.result, wb.data);
    assign rs2_fwd = mux_source(rs2_sel, rs2_value, ex_mem.result, wb.data);

endmodule

// File: rv_ex_cfg.svh
// RV32I execute cluster configuration
`ifndef RV_EX_CFG_SVH
`define RV_EX_CFG_SVH

// Data path width
`define XLEN 32

// Register file index width
`define REG_ADDR_W 5

// Link address increment for jal and jalr
`define PC_STEP 4

`endif

// File: rv_ex_pkg.sv
// RV32I execute cluster types
`include "rv_ex_cfg.svh"

package rv_ex_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        alu_add  = 5'd0,
        alu_sub  = 5'd1,
        alu_sll  = 5'd2,
        alu_slt  = 5'd3,
        alu_sltu = 5'd4,
        alu_xor  = 5'd5,
        alu_srl  = 5'd6,
        alu_sra  = 5'd7,
        alu_or   = 5'd8,
        alu_and  = 5'd9
    } alu_fn_t;

    // Operand classes with 3'b110 unused
    typedef enum logic [2:0] {
        oc_load_store = 3'b000,   // rs1, imm
        oc_branch     = 3'b001,   // rs1, rs2
        oc_reg_imm    = 3'b010,   // rs1, rs2 or imm
        oc_jal        = 3'b011,   // pc, step
        oc_lui        = 3'b100,   // imm, zero
        oc_auipc      = 3'b101,   // pc, imm
        oc_jalr       = 3'b111    // pc, step
    } op_class_t;

    // Same codes as funct3
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_t;

    typedef enum logic [1:0] {
        fwd_none        = 2'd0,
        fwd_from_ex_mem = 2'd1,
        fwd_from_wb     = 2'd2
    } fwd_sel_t;

    // Decoded instruction as issued to EX
    typedef struct packed {
        logic      valid;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        word_t     rs1_value;
        word_t     rs2_value;
        word_t     imm;
        word_t     pc;
        op_class_t op_class;
        alu_fn_t   alu_fn;
        logic      alu_src;      // Second operand is imm
        logic      branch;
        branch_t   branch_type;
        logic      jump;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      reg_write;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      pc_redirect;
        word_t     redirect_target;
    } ex_mem_t;

    // Final write-back value
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     data;
    } wb_fwd_t;

endpackage

// File: tb_ex_pipeline.sv
// Execute cluster testbench
`timescale 1ns/1ps
`include "rv_ex_cfg.svh"

module tb_ex_pipeline
    import rv_ex_pkg::*;
;

    localparam int M_IDLE = 0;
    localparam int M_ARITH = 1;
    localparam int M_CTRL = 2;
    localparam int M_FWD = 3;
    localparam int M_MIX = 4;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_LIMIT = 16;

    logic    clk;
    logic    rst;
    logic    stall;
    id_ex_t  issue;
    wb_fwd_t wb;
    ex_mem_t ex_mem;

    logic [31:0] lfsr;
    id_ex_t      exp_idex;   // Model of the ID/EX register
    ex_mem_t     exp_em;     // Model of the EX/MEM register
    logic        next_valid;
    logic        timed_out;
    int          errors;
    int          checks;
    int          tests;

    ex_pipeline uut (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .issue  (issue),
        .wb     (wb),
        .ex_mem (ex_mem)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < width; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        return (rand_bits(1) != 0);
    endfunction

    function automatic word_t expected_alu(alu_fn_t fn, word_t a, word_t b);
        case (fn)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return '0;
        endcase
    endfunction

    // Expected EX/MEM bundle for one latched instruction
    function automatic ex_mem_t expected_execute(id_ex_t e);
        ex_mem_t r;
        word_t   a;
        word_t   b;
        word_t   jsum;
        alu_fn_t fn;
        logic    taken;
        a = e.rs1_value;
        b = e.rs2_value;
        fn = e.alu_fn;
        case (e.op_class)
            oc_load_store: b = e.imm;
            oc_reg_imm:    b = e.alu_src ? e.imm : e.rs2_value;
            oc_jal, oc_jalr:
            begin
                a = e.pc;
                b = word_t'(`PC_STEP);
                fn = alu_add;   // Link address
            end
            oc_lui:
            begin
                a = e.imm;
                b = '0;
            end
            oc_auipc:
            begin
                a = e.pc;
                b = e.imm;
            end
            default: ;
        endcase
        case (e.branch_type)
            br_beq:  taken = (e.rs1_value == e.rs2_value);
            br_bne:  taken = (e.rs1_value != e.rs2_value);
            br_blt:  taken = ($signed(e.rs1_value) < $signed(e.rs2_value));
            br_bge:  taken = ($signed(e.rs1_value) >= $signed(e.rs2_value));
            br_bltu: taken = (e.rs1_value < e.rs2_value);
            br_bgeu: taken = (e.rs1_value >= e.rs2_value);
            default: taken = 1'b0;
        endcase
        r = '0;
        r.valid = e.valid;
        r.result = expected_alu(fn, a, b);
        r.store_data = e.rs2_value;
        r.rd = e.rd;
        r.reg_write = e.valid & e.reg_write;
        r.mem_read = e.valid & e.mem_read;
        r.mem_write = e.valid & e.mem_write;
        r.mem_to_reg = e.mem_to_reg;
        r.pc_redirect = e.valid & (e.jump | (e.branch & taken));
        jsum = e.rs1_value + e.imm;
        if (e.op_class == oc_jalr)
            r.redirect_target = {jsum[`XLEN-1:1], 1'b0};
        else
            r.redirect_target = e.pc + e.imm;
        return r;
    endfunction

    // Bypass rule with EX/MEM first and never from x0
    function automatic word_t bypass_value(reg_addr_t src, word_t value, ex_mem_t em,
                                           wb_fwd_t w);
        if (src == '0)
            return value;
        if (em.valid && em.reg_write && (em.rd == src))
            return em.result;
        if (w.reg_write && (w.rd == src))
            return w.data;
        return value;
    endfunction

    task automatic make_issue(input int mode, input int n, output id_ex_t e);
        int k;
        e = '0;
        e.valid = 1'b1;
        e.rs1_addr = reg_addr_t'(rand_bits(5));
        e.rs2_addr = reg_addr_t'(rand_bits(5));
        e.rs1_value = rand_bits(32);
        e.rs2_value = rand_bits(32);
        e.imm = rand_bits(32);
        e.pc = rand_bits(32) & 32'hffff_fffc;
        e.rd = reg_addr_t'(rand_bits(5));
        e.reg_write = 1'b1;
        e.op_class = oc_reg_imm;
        e.alu_fn = alu_add;
        case (mode)
            M_ARITH:
            begin
                k = n % 8;
                if (k < 5)
                begin
                    e.alu_fn = alu_fn_t'(5'(n % 10));
                    e.alu_src = rand_bit();
                end
                else if (k == 5)
                begin
                    e.op_class = oc_load_store;
                    e.mem_write = rand_bit();
                    e.mem_read = ~e.mem_write;
                    e.mem_to_reg = e.mem_read;
                    e.reg_write = e.mem_read;
                end
                else
                    e.op_class = (k == 6) ? oc_lui : oc_auipc;
            end
            M_CTRL:
            begin
                k = n % 8;
                if (k < 6)
                begin
                    e.op_class = oc_branch;
                    e.branch = 1'b1;
                    e.reg_write = 1'b0;
                    e.branch_type = branch_t'(3'(k < 2 ? k : k + 2));   // funct3 codes
                    if (rand_bit())
                        e.rs1_value = e.rs2_value;   // Equal pair
                end
                else
                begin
                    e.op_class = (k == 6) ? oc_jal : oc_jalr;
                    e.jump = 1'b1;
                end
            end
            M_FWD, M_MIX:
            begin
                // Few registers so sources often hit in-flight writers
                e.alu_fn = alu_fn_t'(5'(rand_bits(4) % 10));
                e.rs1_addr = reg_addr_t'(rand_bits(2));
                e.rs2_addr = reg_addr_t'(rand_bits(2));
                e.rd = reg_addr_t'(rand_bits(2));
                if (mode == M_MIX)
                    e.valid = (rand_bits(2) != 0);
            end
            default:
            begin
                // Bubble with live side effect bits
                e.valid = 1'b0;
                e.jump = rand_bit();
                e.mem_read = rand_bit();
                e.mem_write = rand_bit();
            end
        endcase
    endtask

    task automatic step_cycle(input int mode, input int n);
        id_ex_t  cap;
        id_ex_t  nxt;
        wb_fwd_t nwb;
        logic    nstall;
        @(posedge clk);
        // Model follows the registers on this edge
        if (!stall)
        begin
            cap = issue;
            cap.rs1_value = bypass_value(issue.rs1_addr, issue.rs1_value, exp_em, wb);
            cap.rs2_value = bypass_value(issue.rs2_addr, issue.rs2_value, exp_em, wb);
            exp_em = expected_execute(exp_idex);
            exp_idex = cap;
        end
        make_issue(mode, n, nxt);
        nwb = '0;
        nstall = 1'b0;
        if (mode == M_FWD || mode == M_MIX)
        begin
            nwb.reg_write = rand_bit();
            nwb.rd = reg_addr_t'(rand_bits(2));
            nwb.data = rand_bits(32);
        end
        if (mode == M_MIX)
            nstall = (rand_bits(2) == 0);
        next_valid = nxt.valid;
        issue <= nxt;
        wb <= nwb;
        stall <= nstall;
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while ((next_valid || exp_idex.valid || exp_em.valid) && waited < DRAIN_LIMIT)
        begin
            step_cycle(M_IDLE, 0);
            waited++;
        end
        if (next_valid || exp_idex.valid || exp_em.valid)
        begin
            timed_out = 1'b1;
            $display("timeout: pipeline still busy after %0d idle cycles", DRAIN_LIMIT);
        end
        step_cycle(M_IDLE, 0);   // Last check lands on the negedge before this
    endtask

    task automatic run_test(input string name, input int mode, input int count);
        int err0;
        int chk0;
        int n;
        err0 = errors;
        chk0 = checks;
        if (!timed_out)
        begin
            for (n = 0; n < count; n++)
                step_cycle(mode, n);
            drain_pipeline();
            tests++;
            $display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
        end
    endtask

    task automatic check_field(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("mismatch at %0t ns: ex_mem.%s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Compare on the falling edge away from register updates
    always @(negedge clk)
    begin
        if (!rst)
        begin
            check_field("valid", word_t'(ex_mem.valid), word_t'(exp_em.valid));
            check_field("reg_write", word_t'(ex_mem.reg_write), word_t'(exp_em.reg_write));
            check_field("mem_read", word_t'(ex_mem.mem_read), word_t'(exp_em.mem_read));
            check_field("mem_write", word_t'(ex_mem.mem_write), word_t'(exp_em.mem_write));
            check_field("pc_redirect", word_t'(ex_mem.pc_redirect),
                        word_t'(exp_em.pc_redirect));
            if (exp_em.valid)
            begin
                check_field("result", ex_mem.result, exp_em.result);
                check_field("store_data", ex_mem.store_data, exp_em.store_data);
                check_field("redirect_target", ex_mem.redirect_target, exp_em.redirect_target);
                check_field("rd", word_t'(ex_mem.rd), word_t'(exp_em.rd));
                check_field("mem_to_reg", word_t'(ex_mem.mem_to_reg),
                            word_t'(exp_em.mem_to_reg));
            end
        end
    end

    initial
    begin
        int i;
        lfsr = 32'h757c_0e26;
        errors = 0;
        checks = 0;
        tests = 0;
        timed_out = 1'b0;
        next_valid = 1'b0;
        exp_idex = '0;
        exp_em = '0;
        rst = 1'b1;
        stall = 1'b0;
        issue = '0;
        wb = '0;
        for (i = 0; i < RESET_CYCLES; i++)
            @(posedge clk);
        rst <= 1'b0;
        run_test("reset", M_IDLE, 6);
        run_test("arithmetic", M_ARITH, 80);
        run_test("control", M_CTRL, 64);
        run_test("forwarding", M_FWD, 80);
        run_test("stall and bubbles", M_MIX, 120);
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
